//--- include/lineBuf_consts.svh
`ifndef LINEBUF_CONSTS_SVH
`define LINEBUF_CONSTS_SVH

// Line buffer geometry
// ----------------------------------------

// Line address bits, gives 32 lines
`define LB_LINE_ADDR_W 5

// Width of one data word
`define LB_WORD_W 32

// Words packed into one refill line
`define LB_WORDS_PER_LINE 4

// Word address is the line address plus a 2 bit word select
`define LB_WORD_ADDR_W 7

// Independent read lanes
`define LB_N_LANES 4

`endif

//--- logic/lbLinePkg.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Storage side and refill side types
package lbLinePkg;

    // One data word as held in storage
    typedef logic [`LB_WORD_W-1:0] wordT;

    // Line index into the 32 line store
    typedef logic [`LB_LINE_ADDR_W-1:0] lineAddrT;

    // A line is written flat by the refill port
    // and picked apart word by word on the read side
    // Word 0 sits in the low bits
    typedef union packed {
        logic [`LB_WORDS_PER_LINE*`LB_WORD_W-1:0] flat;
        wordT [`LB_WORDS_PER_LINE-1:0]            words;
    } lineT;

    // Refill beat, one whole line per transfer
    typedef struct packed {
        lineAddrT addr;
        lineT     data;
    } refillT;

endpackage

`default_nettype wire

//--- logic/lbLanePkg.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Read lane traffic types
package lbLanePkg;

    // Request word address
    // Upper bits pick the line, lower bits the word in it
    typedef struct packed {
        logic [`LB_LINE_ADDR_W-1:0]                  line;
        logic [`LB_WORD_ADDR_W-`LB_LINE_ADDR_W-1:0]  word;
    } laneReqT;

    // Response carries only the data word
    typedef struct packed {
        logic [`LB_WORD_W-1:0] data;
    } laneRspT;

endpackage

`default_nettype wire

//--- logic/lbRefillStage.sv
`default_nettype none

// Refill sample stage
// Every refill is taken, there is no ready
// The sampled line goes to the store on the following edge
module lbRefillStage
(
    input  logic                 clk,
    input  logic                 arstN,

    // Refill port from outside
    input  logic                 refillValid,
    input  lbLinePkg::refillT    refill,

    // Commit towards store and hazard marker towards ctrl
    output logic                 pendValid,
    output lbLinePkg::lineAddrT  pendLine,
    output lbLinePkg::lineT      commitLine
);

    // ----------------------------------------
    // Commit valid
    // ----------------------------------------

    // High for exactly the cycle after each accepted refill
    always_ff @(posedge clk or negedge arstN)
    begin : pPendValid
        if (!arstN)
            pendValid <= 1'b0;
        else
            pendValid <= refillValid;
    end

    // ----------------------------------------
    // Sample line address and data
    // ----------------------------------------

    // Payload only, loads on accept
    // Refill side sees the line as one flat value
    always_ff @(posedge clk)
    begin : pSample
        if (refillValid)
        begin
            pendLine        <= refill.addr;
            commitLine.flat <= refill.data.flat;
        end
    end

endmodule

`default_nettype wire

//--- logic/lbWordStore.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Line store, one full line write port
// and one narrow word read port per lane
module lbWordStore
(
    input  logic                                          clk,

    // Write port, whole line per commit
    input  logic                                          writeEnable,
    input  lbLinePkg::lineAddrT                           writeLine,
    input  lbLinePkg::lineT                               writeData,

    // Read ports, word granular
    input  logic [`LB_N_LANES-1:0]                        readEnable,
    input  logic [`LB_N_LANES-1:0][`LB_WORD_ADDR_W-1:0]   readAddr,
    output lbLinePkg::wordT [`LB_N_LANES-1:0]             readData
);

    localparam int NUM_LINES = 2**`LB_LINE_ADDR_W;
    localparam int WSEL_W    = `LB_WORD_ADDR_W - `LB_LINE_ADDR_W;

    // Flop storage, contents undefined until a line is written
    lbLinePkg::lineT                               memLines [NUM_LINES];

    // One hot line write enable
    logic [NUM_LINES-1:0]                          lineEnable;

    // Read address registers, one per lane
    logic [`LB_N_LANES-1:0][`LB_WORD_ADDR_W-1:0]   rAddrReg;

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    generate
        for (genvar z = 0; z < `LB_N_LANES; z++)
        begin : gRead
            // Address held until the lane issues again
            always_ff @(posedge clk)
            begin : pRAddrReg
                if (readEnable[z])
                    rAddrReg[z] <= readAddr[z];
            end

            // Line select from the upper bits, word select from the low bits
            assign readData[z] =
                memLines[rAddrReg[z][`LB_WORD_ADDR_W-1:WSEL_W]].words[rAddrReg[z][WSEL_W-1:0]];
        end
    endgenerate

    // ----------------------------------------
    // Write side
    // ----------------------------------------

    // Line decoder
    always_comb
    begin : pLineDec
        for (int i = 0; i < NUM_LINES; i++)
        begin
            lineEnable[i] = writeEnable && (writeLine == lbLinePkg::lineAddrT'(i));
        end
    end

    // Per line write enable, no gated clock
    always_ff @(posedge clk)
    begin : pWrite
        for (int k = 0; k < NUM_LINES; k++)
        begin
            if (lineEnable[k])
                memLines[k] <= writeData;
        end
    end

    // Never two lines written by one commit
    aLineOneHot: assert property (@(posedge clk) $onehot0(lineEnable));

endmodule

`default_nettype wire

//--- logic/lbReadLane.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Lane output register
// Holds one response until the consumer takes it
module lbReadLane
(
    input  logic                     clk,
    input  logic                     arstN,

    // From ctrl and store
    input  logic                     capture,
    input  logic [`LB_WORD_W-1:0]    word,

    // Response port
    output logic                     rspValid,
    output lbLanePkg::laneRspT       rsp,
    input  logic                     rspReady,

    // Occupancy back to ctrl
    output logic                     full
);

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------

    // Capture wins over drain, a new word replaces one being taken
    always_ff @(posedge clk or negedge arstN)
    begin : pValid
        if (!arstN)
            rspValid <= 1'b0;
        else if (capture)
            rspValid <= 1'b1;
        else if (rspReady)
            rspValid <= 1'b0;
    end

    // Data register, loads only on capture
    always_ff @(posedge clk)
    begin : pData
        if (capture)
            rsp.data <= word;
    end

    assign full = rspValid;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Waiting response stays put until taken
    aRspStable: assert property (@(posedge clk) disable iff (!arstN)
        rspValid && !rspReady |=> rspValid && $stable(rsp));

    // Ctrl must never issue into a blocked lane
    aNoOverrun: assert property (@(posedge clk) disable iff (!arstN)
        capture |-> !full || rspReady);

endmodule

`default_nettype wire

//--- logic/lbCtrl.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Lane acceptance and read issue
// Stalls requests that hit a line with an uncommitted refill
module lbCtrl
(
    input  logic                                   clk,
    input  logic                                   arstN,

    // Refill in flight, both stages
    input  logic                                   refillValid,
    input  lbLinePkg::lineAddrT                    refillLine,
    input  logic                                   pendValid,
    input  lbLinePkg::lineAddrT                    pendLine,

    // Lane requests
    input  logic [`LB_N_LANES-1:0]                 reqValid,
    input  lbLinePkg::lineAddrT [`LB_N_LANES-1:0]  reqLine,

    // Lane output state
    input  logic [`LB_N_LANES-1:0]                 full,
    input  logic [`LB_N_LANES-1:0]                 rspReady,

    output logic [`LB_N_LANES-1:0]                 reqReady,
    output logic [`LB_N_LANES-1:0]                 readEnable,
    output logic [`LB_N_LANES-1:0]                 capture
);

    // Per lane stall terms
    logic [`LB_N_LANES-1:0] hazardStall;
    logic [`LB_N_LANES-1:0] backStall;

    // Read issued last edge, captures on the next one
    logic [`LB_N_LANES-1:0] issued;

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------

    always_comb
    begin : pAccept
        for (int l = 0; l < `LB_N_LANES; l++)
        begin
            // Line still waiting for its commit, or being refilled right now
            hazardStall[l] = (pendValid && (pendLine == reqLine[l]))
                          || (refillValid && (refillLine == reqLine[l]));

            // Lane register blocked
            // An issue in flight also blocks, the capture it owes
            // would land on a full lane if the consumer stalls next cycle
            backStall[l] = issued[l] || (full[l] && !rspReady[l]);

            reqReady[l]   = !hazardStall[l] && !backStall[l];
            readEnable[l] = reqValid[l] && reqReady[l];
        end
    end

    // ----------------------------------------
    // Issue tracking
    // ----------------------------------------

    always_ff @(posedge clk or negedge arstN)
    begin : pIssued
        if (!arstN)
            issued <= '0;
        else
            issued <= readEnable;
    end

    // Word sits on readData for one cycle after the address loads
    assign capture = issued;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    generate
        for (genvar l = 0; l < `LB_N_LANES; l++)
        begin : gChk
            // No read may start on a line with a commit waiting
            aNoPendRead: assert property (@(posedge clk) disable iff (!arstN)
                readEnable[l] |-> !(pendValid && (pendLine == reqLine[l])));

            // Store line must not change on the edge that captures the word
            aNoCommitOnCapture: assert property (@(posedge clk) disable iff (!arstN)
                readEnable[l] |=> !(pendValid && (pendLine == $past(reqLine[l]))));
        end
    endgenerate

endmodule

`default_nettype wire

//--- logic/lineBuffer.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Line buffer top
// Line wide refill in, four word wide read lanes out
module lineBuffer
(
    input  logic                                   clk,
    input  logic                                   arstN,

    // Refill port, always accepted
    input  logic                                   refillValid,
    input  lbLinePkg::refillT                      refill,

    // Lane request ports
    input  logic [`LB_N_LANES-1:0]                 reqValid,
    input  lbLanePkg::laneReqT [`LB_N_LANES-1:0]   req,
    output logic [`LB_N_LANES-1:0]                 reqReady,

    // Lane response ports
    output logic [`LB_N_LANES-1:0]                 rspValid,
    output lbLanePkg::laneRspT [`LB_N_LANES-1:0]   rsp,
    input  logic [`LB_N_LANES-1:0]                 rspReady
);

    // Refill commit path
    logic                                  pendValid;
    lbLinePkg::lineAddrT                   pendLine;
    lbLinePkg::lineT                       commitLine;

    // Lane side wiring
    lbLinePkg::lineAddrT [`LB_N_LANES-1:0] reqLine;
    logic [`LB_N_LANES-1:0]                readEnable;
    logic [`LB_N_LANES-1:0]                capture;
    logic [`LB_N_LANES-1:0]                laneFull;
    lbLinePkg::wordT [`LB_N_LANES-1:0]     laneWord;

    lbRefillStage uRefill
    (
        .clk         ( clk         ),
        .arstN       ( arstN       ),
        .refillValid ( refillValid ),
        .refill      ( refill      ),
        .pendValid   ( pendValid   ),
        .pendLine    ( pendLine    ),
        .commitLine  ( commitLine  )
    );

    lbCtrl uCtrl
    (
        .clk         ( clk         ),
        .arstN       ( arstN       ),
        .refillValid ( refillValid ),
        .refillLine  ( refill.addr ),
        .pendValid   ( pendValid   ),
        .pendLine    ( pendLine    ),
        .reqValid    ( reqValid    ),
        .reqLine     ( reqLine     ),
        .full        ( laneFull    ),
        .rspReady    ( rspReady    ),
        .reqReady    ( reqReady    ),
        .readEnable  ( readEnable  ),
        .capture     ( capture     )
    );

    // Full word address goes straight to the read address registers
    lbWordStore uStore
    (
        .clk         ( clk         ),
        .writeEnable ( pendValid   ),
        .writeLine   ( pendLine    ),
        .writeData   ( commitLine  ),
        .readEnable  ( readEnable  ),
        .readAddr    ( req         ),
        .readData    ( laneWord    )
    );

    // ----------------------------------------
    // Lanes
    // ----------------------------------------

    generate
        for (genvar l = 0; l < `LB_N_LANES; l++)
        begin : gLane
            // Hazard check needs only the line part
            assign reqLine[l] = req[l].line;

            lbReadLane uLane
            (
                .clk      ( clk          ),
                .arstN    ( arstN        ),
                .capture  ( capture[l]   ),
                .word     ( laneWord[l]  ),
                .rspValid ( rspValid[l]  ),
                .rsp      ( rsp[l]       ),
                .rspReady ( rspReady[l]  ),
                .full     ( laneFull[l]  )
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- verification/lbChecker.sv
`default_nettype none

`include "lineBuf_consts.svh"

// Watches the DUT ports and models the line contents
// Each response is matched against the word its request should see
module lbChecker
(
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  refillValid,
    input  lbLinePkg::refillT                     refill,
    input  logic [`LB_N_LANES-1:0]                reqValid,
    input  lbLanePkg::laneReqT [`LB_N_LANES-1:0]  req,
    input  logic [`LB_N_LANES-1:0]                reqReady,
    input  logic [`LB_N_LANES-1:0]                rspValid,
    input  lbLanePkg::laneRspT [`LB_N_LANES-1:0]  rsp,
    input  logic [`LB_N_LANES-1:0]                rspReady,

    // Totals for the closing report
    output int                                    errCount,
    output int                                    rspCount,
    output int                                    outstanding
);

    // Line contents as the refills left them
    lbLinePkg::lineT modelLines [2**`LB_LINE_ADDR_W];

    // Expected words per lane, oldest request first
    lbLinePkg::wordT expQ [`LB_N_LANES][$];

    // Accepted on a free lane one and two edges ago
    logic [`LB_N_LANES-1:0] latFirst;
    logic [`LB_N_LANES-1:0] latSecond;

    // Refill taken on the previous edge, its commit is still pending
    logic                   prevRefillValid;
    lbLinePkg::lineAddrT    prevRefillLine;

    // Reference word, line from the upper bits, word from the low two
    function automatic lbLinePkg::wordT expectedWord(input lbLanePkg::laneReqT r);
        expectedWord = modelLines[r.line].words[r.word];
    endfunction

    always @(posedge clk)
    begin : pCompare
        lbLinePkg::wordT expWord;
        if (!arstN)
        begin
            errCount        = 0;
            rspCount        = 0;
            outstanding     = 0;
            latFirst        = '0;
            latSecond       = '0;
            prevRefillValid = 1'b0;
            prevRefillLine  = '0;
        end
        else
        begin
            // A refill counts for reads accepted on its own edge
            if (refillValid)
                modelLines[refill.addr] = refill.data;

            for (int l = 0; l < `LB_N_LANES; l++)
            begin
                // Free lane answers one cycle after acceptance
                if (latSecond[l] && !rspValid[l])
                begin
                    $display("ERROR lane %0d rspValid expected %h got %h", l, 1'b1, rspValid[l]);
                    errCount++;
                end
                latSecond[l] = latFirst[l];
                latFirst[l]  = reqValid[l] && reqReady[l] && !rspValid[l];

                // No acceptance on a line with an uncommitted refill
                // or while the lane holds a word nobody takes
                if (reqValid[l] && reqReady[l]
                    && ((refillValid && (refill.addr == req[l].line))
                        || (prevRefillValid && (prevRefillLine == req[l].line))
                        || (rspValid[l] && !rspReady[l])))
                begin
                    $display("ERROR lane %0d reqReady expected %h got %h",
                             l, 1'b0, reqReady[l]);
                    errCount++;
                end

                // Older response leaves before this edge's request joins
                if (rspValid[l] && rspReady[l])
                begin
                    if (expQ[l].size() == 0)
                    begin
                        $display("Lane %0d returned a response that no request asked for", l);
                        errCount++;
                    end
                    else
                    begin
                        expWord = expQ[l].pop_front();
                        outstanding--;
                        rspCount++;
                        if (rsp[l].data !== expWord)
                        begin
                            $display("ERROR lane %0d rsp.data expected %h got %h",
                                     l, expWord, rsp[l].data);
                            errCount++;
                        end
                    end
                end

                if (reqValid[l] && reqReady[l])
                begin
                    expQ[l].push_back(expectedWord(req[l]));
                    outstanding++;
                end
            end

            prevRefillValid = refillValid;
            prevRefillLine  = refill.addr;
        end
    end

endmodule

`default_nettype wire

//--- verification/tbLineBuffer.sv
`default_nettype none

`include "lineBuf_consts.svh"

module tbLineBuffer;

    localparam int NL        = `LB_N_LANES;
    localparam int NUM_LINES = 2**`LB_LINE_ADDR_W;
    localparam int REQ_DEPTH = 256;

    // Refills and requests over all tests, sets the watchdog
    localparam int NUM_OPS =
        NUM_LINES + NUM_LINES*`LB_WORDS_PER_LINE*NL
        + 16 + 60*NL + 1 + 2*NL + NL + 2 + NL;
    localparam int TIMEOUT_CYCLES = NUM_OPS*20 + 100;

    logic                         clk;
    logic                         arstN;
    logic                         refillValid;
    lbLinePkg::refillT            refill;
    logic [NL-1:0]                reqValid;
    lbLanePkg::laneReqT [NL-1:0]  req;
    logic [NL-1:0]                reqReady;
    logic [NL-1:0]                rspValid;
    lbLanePkg::laneRspT [NL-1:0]  rsp;
    logic [NL-1:0]                rspReady;

    // Checker totals
    int errCount;
    int rspCount;
    int outstanding;

    logic [15:0] lfsrState;

    // Stimulus waiting to go out
    lbLanePkg::laneReqT reqBuf [NL][REQ_DEPTH];
    int                 reqHead [NL];
    int                 reqTail [NL];
    lbLinePkg::refillT  rfBuf [64];
    int                 rfHead;
    int                 rfTail;

    // Random consumer stalls, random gaps between refills
    logic randReady;
    logic randGap;

    lineBuffer dut0 (.*);

    lbChecker chk0 (.*);

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        lfsrNext = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit, newest bit lowest
    function automatic logic [127:0] randBits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v         = {v[126:0], lfsrState[15]};
        end
        randBits = v;
    endfunction

    task automatic queueReq(input int lane, input logic [`LB_WORD_ADDR_W-1:0] addr);
        reqBuf[lane][reqTail[lane]] = addr;
        reqTail[lane]++;
    endtask

    task automatic queueRefill(input lbLinePkg::lineAddrT line, input logic [127:0] data);
        rfBuf[rfTail].addr      = line;
        rfBuf[rfTail].data.flat = data;
        rfTail++;
    endtask

    // Feed queued refills and requests until every response is back
    task automatic runTraffic();
        logic busy;
        do
        begin
            @(negedge clk);
            busy        = (rfHead != rfTail) || (outstanding != 0);
            refillValid = 1'b0;
            if ((rfHead != rfTail) && (!randGap || (randBits(1) != '0)))
            begin
                refillValid = 1'b1;
                refill      = rfBuf[rfHead];
                rfHead++;
            end
            for (int l = 0; l < NL; l++)
            begin
                busy        = busy || (reqHead[l] != reqTail[l]);
                reqValid[l] = (reqHead[l] != reqTail[l]);
                // Held stable until taken
                if (reqValid[l])
                    req[l] = reqBuf[l][reqHead[l]];
                rspReady[l] = !randReady || (randBits(1) != '0);
            end
            // Handshake seen with pre-edge values
            if (busy)
            begin
                @(posedge clk);
                for (int l = 0; l < NL; l++)
                    if (reqValid[l] && reqReady[l])
                        reqHead[l]++;
            end
        end
        while (busy);
    endtask

    initial
    begin : pClock
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin : pWatchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, responses stopped arriving", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin : pMain
        logic [127:0] v;
        int           totalReq;

        lfsrState   = 16'd45;
        arstN       = 1'b0;
        refillValid = 1'b0;
        refill      = '0;
        reqValid    = '0;
        req         = '0;
        rspReady    = '0;
        randReady   = 1'b0;
        randGap     = 1'b0;
        rfHead      = 0;
        rfTail      = 0;
        for (int l = 0; l < NL; l++)
        begin
            reqHead[l] = 0;
            reqTail[l] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // ----------------------------------------
        // Fill every line, each lane reads every word
        for (int n = 0; n < NUM_LINES; n++)
            queueRefill(n[`LB_LINE_ADDR_W-1:0], randBits(128));
        runTraffic();
        for (int l = 0; l < NL; l++)
            for (int a = 0; a < NUM_LINES*`LB_WORDS_PER_LINE; a++)
                queueReq(l, a[`LB_WORD_ADDR_W-1:0]);
        runTraffic();

        // ----------------------------------------
        // Random reads and refills, consumer stalls at random
        randReady = 1'b1;
        randGap   = 1'b1;
        for (int n = 0; n < 16; n++)
        begin
            v = randBits(`LB_LINE_ADDR_W);
            queueRefill(v[`LB_LINE_ADDR_W-1:0], randBits(128));
        end
        for (int l = 0; l < NL; l++)
            for (int n = 0; n < 60; n++)
            begin
                v = randBits(`LB_WORD_ADDR_W);
                queueReq(l, v[`LB_WORD_ADDR_W-1:0]);
            end
        runTraffic();
        randReady = 1'b0;
        randGap   = 1'b0;

        // ----------------------------------------
        // Same line refill and reads together, reads stall for the new line
        queueRefill(5'd9, randBits(128));
        for (int l = 0; l < NL; l++)
        begin
            queueReq(l, {5'd9, 2'(l)});
            queueReq(l, {5'd9, 2'(NL-1-l)});
        end
        runTraffic();

        // All lanes hit one word on one edge
        for (int l = 0; l < NL; l++)
            queueReq(l, 7'h2d);
        runTraffic();

        // Back to back refills of one line, later one must win
        queueRefill(5'd20, randBits(128));
        queueRefill(5'd20, randBits(128));
        for (int l = 0; l < NL; l++)
            queueReq(l, {5'd20, 2'(l)});
        runTraffic();

        totalReq = 0;
        for (int l = 0; l < NL; l++)
            totalReq += reqTail[l];
        @(negedge clk);
        $display("Responses %0d of %0d, errors %0d, unanswered %0d",
                 rspCount, totalReq, errCount, outstanding);
        if (errCount == 0 && outstanding == 0 && rspCount == totalReq)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
logic/lbLinePkg.sv
logic/lbLanePkg.sv
logic/lbRefillStage.sv
logic/lbWordStore.sv
logic/lbReadLane.sv
logic/lbCtrl.sv
logic/lineBuffer.sv
verification/lbChecker.sv
verification/tbLineBuffer.sv

//--- run.sh
#!/bin/sh
# Build the line buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbLineBuffer -o simLineBuffer

./obj_dir/simLineBuffer | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
